/* bf_spi_master.sv */
// ====================
// LM96570 SPI master, variable-length frame out on SDO
// and captured back from SDI
// ====================

`timescale 1ns/1ps
`default_nettype none

module bf_spi_master (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 start,       // one-cycle request
	input  logic [us_pkg::BF_DATA_WIDTH-1:0]      data_in,     // frame, right-aligned
	input  logic [us_pkg::BF_BIT_COUNT_WIDTH-1:0] num_of_bit,  // 1..70
	input  logic                                 spi_sdi,
	output logic                                 done,        // one-cycle pulse
	output logic [us_pkg::BF_DATA_WIDTH-1:0]      rd_data,     // captured frame
	output logic                                 spi_cs_n,
	output logic                                 spi_sck,
	output logic                                 spi_sdo
);

	import us_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_shift,   // bits on the bus
		st_trail,   // SCK low before CS_N rises
		st_done
	} state_t;

	state_t                        state;
	logic [SCK_HALF_CNT_WIDTH-1:0] half_cnt;    // cycles into half period
	logic [BF_BIT_COUNT_WIDTH-1:0] bit_cnt;     // bits left after current
	logic [BF_DATA_WIDTH-1:0]      tx_sr;       // next bit at MSB
	logic [BF_DATA_WIDTH-1:0]      rx_sr;       // shifts in at LSB
	logic [BF_DATA_WIDTH-1:0]      tx_aligned;  // frame moved to MSB
	logic                          half_end;    // last cycle of a half period

	assign tx_aligned = data_in << (BF_DATA_WIDTH - int'(num_of_bit));
	assign half_end   = (half_cnt == SCK_HALF_CNT_WIDTH'(SCK_HALF_CYCLES - 1));

	// ====================
	// control and bus pins
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			half_cnt <= '0;
			bit_cnt  <= '0;
			spi_cs_n <= 1'b1;
			spi_sck  <= 1'b0;
			spi_sdo  <= 1'b0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						state    <= st_shift;
						spi_cs_n <= 1'b0;                   // first bit valid here
						spi_sck  <= 1'b0;
						spi_sdo  <= tx_aligned[BF_DATA_WIDTH-1];
						half_cnt <= '0;
						bit_cnt  <= num_of_bit - 1'b1;
					end
				end
				st_shift: begin
					half_cnt <= half_end ? '0 : half_cnt + 1'b1;
					if (half_end) begin
						if (!spi_sck) begin
							spi_sck <= 1'b1;                // rising edge, sample
						end else begin
							spi_sck <= 1'b0;                // falling edge, next bit
							if (bit_cnt == '0) begin
								state <= st_trail;
							end else begin
								bit_cnt <= bit_cnt - 1'b1;
								spi_sdo <= tx_sr[BF_DATA_WIDTH-2];
							end
						end
					end
				end
				st_trail: begin
					half_cnt <= half_end ? '0 : half_cnt + 1'b1;
					if (half_end) begin
						state    <= st_done;
						spi_cs_n <= 1'b1;                   // end of frame
						spi_sdo  <= 1'b0;
					end
				end
				default: begin                              // st_done
					state <= st_idle;
					done  <= 1'b1;
				end
			endcase
		end
	end

	// ====================
	// shift registers
	// ====================
	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			tx_sr <= tx_aligned;
			rx_sr <= '0;                                    // upper bits end up zero
		end else if (state == st_shift && half_end) begin
			if (!spi_sck)
				rx_sr <= {rx_sr[BF_DATA_WIDTH-2:0], spi_sdi};  // slave bit stable since fall
			else
				tx_sr <= tx_sr << 1;
		end
		if (state == st_done)
			rd_data <= rx_sr;                               // same cycle as done
	end

	// frame length checked only when a request is taken
	a_num_of_bit: assert property (@(posedge clk) disable iff (!rst_n)
		(start && state == st_idle) |->
		(num_of_bit >= 1 && num_of_bit <= BF_DATA_WIDTH));

	// SCK idles low outside a frame
	a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n)
		spi_cs_n |-> !spi_sck);

endmodule

`default_nettype wire

/* delayed_pulser.sv */
// ====================
// rising-edge detector with delayed single-cycle pulse
// ====================

`timescale 1ns/1ps
`default_nettype none

module delayed_pulser #(
	parameter int DELAY = us_pkg::START_DELAY_CYCLES  // cycles edge to pulse
) (
	input  logic clk,
	input  logic rst_n,
	input  logic sig_in,   // host level command
	output logic pulse     // one cycle wide
);

	import us_pkg::*;

	logic                         sig_d;     // previous sample of sig_in
	logic                         sig_rise;  // low then high
	logic                         busy;      // delay running
	logic [START_DELAY_WIDTH-1:0] cnt;       // cycles left

	assign sig_rise = sig_in & ~sig_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sig_d <= 1'b0;
			busy  <= 1'b0;
			cnt   <= '0;
			pulse <= 1'b0;
		end else begin
			sig_d <= sig_in;
			pulse <= 1'b0;                                  // default low
			if (busy) begin
				if (cnt == '0) begin
					pulse <= 1'b1;                          // delay expired
					busy  <= 1'b0;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end else if (sig_rise) begin
				busy <= 1'b1;                               // edges while busy are dropped
				cnt  <= START_DELAY_WIDTH'(DELAY - 1);
			end
		end
	end

	// delay must fit the counter and be non-zero
	a_delay_range: assert property (@(posedge clk) disable iff (!rst_n)
		(DELAY >= 1) && (DELAY < (1 << START_DELAY_WIDTH)));

endmodule

`default_nettype wire

/* echo_acq_fsm.sv */
// ====================
// transmit enable, initial delay and sample window FSM
// ====================

`timescale 1ns/1ps
`default_nettype none

module echo_acq_fsm (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start,                 // one-cycle request
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0] adc_start_length,      // tx_en cycles
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0] adc_init_delay,        // gap cycles
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0] adc_samples_per_echo,  // window cycles
	output logic                            tx_en,                 // beamformer fire
	output logic                            fifo_en,               // sample window
	output logic                            done                   // one-cycle pulse
);

	import us_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_fire,     // tx_en high
		st_wait,     // both low
		st_window    // fifo_en high
	} state_t;

	state_t                   state;
	logic [ACQ_CNT_WIDTH-1:0] cnt;       // cycles left in phase, minus one
	logic                     cnt_zero;  // phase ends this cycle

	assign cnt_zero = (cnt == '0);

	// ====================
	// phase sequencing
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			cnt     <= '0;
			tx_en   <= 1'b0;
			fifo_en <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_fire;
						tx_en <= 1'b1;                      // rises the cycle after start
						cnt   <= adc_start_length - 1'b1;
					end
				end
				st_fire: begin
					if (cnt_zero) begin
						state <= st_wait;
						tx_en <= 1'b0;
						cnt   <= adc_init_delay - 1'b1;     // reload for the gap
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				st_wait: begin
					if (cnt_zero) begin
						state   <= st_window;
						fifo_en <= 1'b1;                    // open sample window
						cnt     <= adc_samples_per_echo - 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: begin                              // st_window
					if (cnt_zero) begin
						state   <= st_idle;
						fifo_en <= 1'b0;
						done    <= 1'b1;                    // right after the window
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// no sampling while the transmitter fires
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(tx_en && fifo_en));

	// a zero length would wrap the counter
	a_lengths: assert property (@(posedge clk) disable iff (!rst_n)
		(start && state == st_idle) |->
		(adc_start_length != '0 && adc_init_delay != '0 &&
		 adc_samples_per_echo != '0));

endmodule

`default_nettype wire

/* project.f */
us_pkg.sv
delayed_pulser.sv
bf_spi_master.sv
echo_acq_fsm.sv
us_frontend_top.sv
tb_us_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_us_frontend -f project.f -o tb_us_frontend \
	&& ./obj_dir/tb_us_frontend > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^All tests passed$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb_us_frontend.sv */
// ====================
// front end testbench, SPI slave model, golden reader and checks
// ====================

`timescale 1ns/1ps
`default_nettype none

module tb_us_frontend;

	import us_pkg::*;

	localparam int NUM_TESTS   = 12;                       // lines in the golden file
	localparam int GOLD_FIELDS = 8;                        // words per line
	localparam int HOLD_CYCLES = 20;                       // levels kept high after done
	localparam int LATENCY     = START_DELAY_CYCLES + 1;   // sampled edge to first effect

	// ====================
	// DUT signals
	// ====================
	logic                          clk = 1'b0;
	logic                          rst_n;
	logic                          bf_spi_start;
	logic                          bf_tx_en;
	logic [BF_DATA_WIDTH-1:0]      data_in;
	logic [BF_BIT_COUNT_WIDTH-1:0] num_of_bit;
	logic [ACQ_CNT_WIDTH-1:0]      adc_start_length;
	logic [ACQ_CNT_WIDTH-1:0]      adc_init_delay;
	logic [ACQ_CNT_WIDTH-1:0]      adc_samples_per_echo;
	logic                          spi_sdi = 1'b0;
	logic                          spi_cs_n;
	logic                          spi_sck;
	logic                          spi_sdo;
	logic                          bf_spi_done;
	logic [BF_DATA_WIDTH-1:0]      rd_data;
	logic                          bf_tx_en_pin;
	logic                          fifo_en;
	logic                          fsm_done;

	logic [71:0]              gold [0:NUM_TESTS*GOLD_FIELDS-1];  // golden words
	int                       cyc = 0;                  // rising edges so far
	int                       cycle_limit = 0;          // 0 until the budget is known
	int                       pass_count = 0;
	int                       fail_count = 0;
	int                       test_errors = 0;          // wrong values in current test
	// slave model
	logic [BF_DATA_WIDTH-1:0] slave_resp;               // answer for the next frame
	int                       slave_nbits;
	logic [BF_DATA_WIDTH-1:0] slave_tx = '0;            // next SDI bit at MSB
	logic [BF_DATA_WIDTH-1:0] slave_cap = '0;           // SDO bits of running frame
	int                       slave_cnt = 0;
	logic [BF_DATA_WIDTH-1:0] frame_bits = '0;          // last finished frame
	int                       frame_cnt = 0;
	// output monitor
	logic                     prev_cs_n = 1'b1;
	logic                     prev_tx = 1'b0;
	logic                     prev_fifo = 1'b0;
	int                       cs_falls = 0;
	int                       spi_dones = 0;
	int                       tx_rises = 0;
	int                       fsm_dones = 0;
	int                       cs_fall_cyc, tx_rise_cyc, tx_fall_cyc;
	int                       fifo_rise_cyc, fifo_fall_cyc, fsm_done_cyc;
	logic [BF_DATA_WIDTH-1:0] rd_seen = '0;

	us_frontend_top us_frontend_top_inst (.*);

	initial forever #10 clk = ~clk;                     // 20 ns period

	// watchdog on the cycle budget
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cycle_limit > 0 && cyc >= cycle_limit) begin
			$display("Timeout: tests still running after %0d cycles", cyc);
			$display("Some tests failed");
			$finish;
		end
	end

	// ====================
	// SPI slave model
	// ====================
	always @(posedge spi_sck or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			frame_bits = slave_cap;                      // frame over
			frame_cnt  = slave_cnt;
			slave_cap  = '0;
			slave_cnt  = 0;
		end else begin
			slave_cap = {slave_cap[BF_DATA_WIDTH-2:0], spi_sdo};
			slave_cnt = slave_cnt + 1;
		end
	end

	// first bit on CS_N fall, then one per SCK fall
	always @(negedge spi_sck or negedge spi_cs_n) begin
		if (!spi_cs_n) begin
			if (slave_cnt == 0)
				slave_tx = slave_resp << (BF_DATA_WIDTH - slave_nbits);
			else
				slave_tx = slave_tx << 1;
			spi_sdi = slave_tx[BF_DATA_WIDTH-1];
		end
	end

	// ====================
	// output monitor, stable values at the falling clock edge
	// ====================
	always @(negedge clk) begin
		if (rst_n) begin
			if (!spi_cs_n && prev_cs_n) begin
				cs_falls++;
				cs_fall_cyc = cyc;
			end
			if (bf_spi_done) begin
				spi_dones++;
				rd_seen = rd_data;                       // valid with done
			end
			if (bf_tx_en_pin && !prev_tx) begin
				tx_rises++;
				tx_rise_cyc = cyc;
			end
			if (!bf_tx_en_pin && prev_tx)
				tx_fall_cyc = cyc;
			if (fifo_en && !prev_fifo)
				fifo_rise_cyc = cyc;
			if (!fifo_en && prev_fifo)
				fifo_fall_cyc = cyc;
			if (fsm_done) begin
				fsm_dones++;
				fsm_done_cyc = cyc;
			end
		end
		prev_cs_n = spi_cs_n;
		prev_tx   = bf_tx_en_pin;
		prev_fifo = fifo_en;
	end

	// ====================
	// helpers
	// ====================
	task automatic next_slot();
		@(posedge clk);
		#1;                                              // drive after the edge
	endtask

	// keep the n low bits of a frame
	function automatic logic [BF_DATA_WIDTH-1:0] low_bits(
		input logic [BF_DATA_WIDTH-1:0] value, input int n);
		logic [BF_DATA_WIDTH-1:0] mask;
		mask = {BF_DATA_WIDTH{1'b1}} >> (BF_DATA_WIDTH - n);
		return value & mask;
	endfunction

	task automatic report_count(input string what, input int got, input int want);
		$display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, want);
		test_errors++;
	endtask

	task automatic report_wide(input string what, input logic [BF_DATA_WIDTH-1:0] got,
		input logic [BF_DATA_WIDTH-1:0] want);
		$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
		test_errors++;
	endtask

	task automatic close_test(input int t, input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("PASS test %0d (%s) at %0t ns", t, name, $time);
		end else begin
			fail_count++;
			$display("FAIL test %0d (%s) at %0t ns, %0d wrong values", t, name, $time,
				test_errors);
		end
		test_errors = 0;
	endtask

	// one golden line, kind 1 SPI, 2 acquisition, 3 both overlapping
	task automatic run_test(input int t);
		int                       b;
		int                       kind;
		int                       nbit;
		int                       spi_edge;
		int                       tx_edge;
		int                       spi_before;
		int                       fsm_before;
		int                       cs_before;
		int                       tx_before;
		logic [BF_DATA_WIDTH-1:0] exp_rd;
		b    = t * GOLD_FIELDS;
		kind = int'(gold[b][3:0]);
		nbit = int'(gold[b + 2][BF_BIT_COUNT_WIDTH-1:0]);
		exp_rd = gold[b + 7][BF_DATA_WIDTH-1:0];
		spi_edge = 0;
		tx_edge  = 0;
		spi_before = spi_dones;
		fsm_before = fsm_dones;
		cs_before  = cs_falls;
		tx_before  = tx_rises;
		next_slot();
		data_in              = gold[b + 1][BF_DATA_WIDTH-1:0];
		num_of_bit           = gold[b + 2][BF_BIT_COUNT_WIDTH-1:0];
		slave_resp           = gold[b + 3][BF_DATA_WIDTH-1:0];
		slave_nbits          = nbit;
		adc_start_length     = gold[b + 4][ACQ_CNT_WIDTH-1:0];
		adc_init_delay       = gold[b + 5][ACQ_CNT_WIDTH-1:0];
		adc_samples_per_echo = gold[b + 6][ACQ_CNT_WIDTH-1:0];
		if (kind != 2) begin
			bf_spi_start = 1'b1;
			spi_edge     = cyc + 1;                      // edge that samples it
		end
		if (kind == 3) begin
			while (cs_falls == cs_before)                // frame on the bus first
				next_slot();
		end
		if (kind != 1) begin
			bf_tx_en = 1'b1;
			tx_edge  = cyc + 1;
		end
		while ((kind != 2 && spi_dones == spi_before) ||
		       (kind != 1 && fsm_dones == fsm_before))
			next_slot();
		repeat (HOLD_CYCLES) next_slot();                // levels still high

		if (kind != 2) begin
			if (frame_cnt != nbit)
				report_count("bits seen by slave", frame_cnt, nbit);
			if (frame_bits != low_bits(data_in, nbit))
				report_wide("SDO frame", frame_bits, low_bits(data_in, nbit));
			if (rd_seen != exp_rd)
				report_wide("rd_data at bf_spi_done", rd_seen, exp_rd);
			if (cs_fall_cyc - spi_edge != LATENCY)
				report_count("cycles to spi_cs_n fall", cs_fall_cyc - spi_edge, LATENCY);
		end
		if (kind != 1) begin
			if (tx_rise_cyc - tx_edge != LATENCY)
				report_count("cycles to bf_tx_en_pin rise", tx_rise_cyc - tx_edge, LATENCY);
			if (tx_fall_cyc - tx_rise_cyc != int'(adc_start_length))
				report_count("bf_tx_en_pin high cycles", tx_fall_cyc - tx_rise_cyc,
					int'(adc_start_length));
			if (fifo_rise_cyc - tx_fall_cyc != int'(adc_init_delay))
				report_count("gap cycles", fifo_rise_cyc - tx_fall_cyc, int'(adc_init_delay));
			if (fifo_fall_cyc - fifo_rise_cyc != int'(adc_samples_per_echo))
				report_count("fifo_en high cycles", fifo_fall_cyc - fifo_rise_cyc,
					int'(adc_samples_per_echo));
			if (fsm_done_cyc != fifo_fall_cyc)
				report_count("fsm_done offset from window end", fsm_done_cyc - fifo_fall_cyc, 0);
		end
		// a held level starts nothing more
		if (cs_falls != cs_before + (kind != 2 ? 1 : 0))
			report_count("spi_cs_n falls", cs_falls - cs_before, kind != 2 ? 1 : 0);
		if (tx_rises != tx_before + (kind != 1 ? 1 : 0))
			report_count("bf_tx_en_pin rises", tx_rises - tx_before, kind != 1 ? 1 : 0);
		if (spi_dones != spi_before + (kind != 2 ? 1 : 0))
			report_count("SPI frames done", spi_dones - spi_before, kind != 2 ? 1 : 0);
		if (fsm_dones != fsm_before + (kind != 1 ? 1 : 0))
			report_count("acquisitions done", fsm_dones - fsm_before, kind != 1 ? 1 : 0);

		bf_spi_start = 1'b0;
		bf_tx_en     = 1'b0;
		repeat (3) next_slot();                          // pulsers see the low level
		close_test(t + 1, kind == 1 ? "spi" : (kind == 2 ? "acq" : "overlap"));
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int b;
		rst_n                = 1'b0;
		bf_spi_start         = 1'b0;
		bf_tx_en             = 1'b0;
		data_in              = '0;
		num_of_bit           = '0;
		adc_start_length     = '0;
		adc_init_delay       = '0;
		adc_samples_per_echo = '0;
		slave_resp           = '0;
		slave_nbits          = 1;
		$readmemh("us_golden.txt", gold);
		cycle_limit = 200;                               // reset plus margin
		for (int t = 0; t < NUM_TESTS; t++) begin
			b = t * GOLD_FIELDS;
			cycle_limit = cycle_limit + 60 + HOLD_CYCLES + LATENCY;
			if (gold[b][3:0] != 4'h2)                    // frame and trailer
				cycle_limit = cycle_limit + (int'(gold[b + 2][7:0]) + 2) * 2 * SCK_HALF_CYCLES;
			if (gold[b][3:0] != 4'h1)
				cycle_limit = cycle_limit + int'(gold[b + 4][ACQ_CNT_WIDTH-1:0]) +
					int'(gold[b + 5][ACQ_CNT_WIDTH-1:0]) + int'(gold[b + 6][ACQ_CNT_WIDTH-1:0]);
		end

		repeat (3) next_slot();
		rst_n = 1'b1;
		@(negedge clk);
		if ({spi_cs_n, spi_sck, bf_tx_en_pin, fifo_en, bf_spi_done, fsm_done} !== 6'b100000) begin
			$display("FAIL %0t ns: outputs after reset are %b, expected 100000", $time,
				{spi_cs_n, spi_sck, bf_tx_en_pin, fifo_en, bf_spi_done, fsm_done});
			test_errors++;
		end
		close_test(0, "reset");

		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* us_frontend_top.sv */
// ====================
// front end top, start pulsers, beamformer SPI master
// and echo acquisition FSM
// ====================

`timescale 1ns/1ps
`default_nettype none

module us_frontend_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	// host commands
	input  logic                                 bf_spi_start,          // level, rise starts frame
	input  logic                                 bf_tx_en,              // level, rise starts echo
	input  logic [us_pkg::BF_DATA_WIDTH-1:0]      data_in,
	input  logic [us_pkg::BF_BIT_COUNT_WIDTH-1:0] num_of_bit,
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0]      adc_start_length,
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0]      adc_init_delay,
	input  logic [us_pkg::ACQ_CNT_WIDTH-1:0]      adc_samples_per_echo,
	// beamformer SPI
	input  logic                                 spi_sdi,
	output logic                                 spi_cs_n,
	output logic                                 spi_sck,
	output logic                                 spi_sdo,
	// host status
	output logic                                 bf_spi_done,
	output logic [us_pkg::BF_DATA_WIDTH-1:0]      rd_data,
	output logic                                 bf_tx_en_pin,          // beamformer TX enable
	output logic                                 fifo_en,               // sample window
	output logic                                 fsm_done
);

	logic spi_start_pulse;  // delayed frame request
	logic tx_start_pulse;   // delayed acquisition request

	// ====================
	// beamformer SPI path
	// ====================
	delayed_pulser spi_start_pulser (
		.clk    (clk),
		.rst_n  (rst_n),
		.sig_in (bf_spi_start),
		.pulse  (spi_start_pulse)
	);

	bf_spi_master bf_spi_master_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (spi_start_pulse),
		.data_in    (data_in),
		.num_of_bit (num_of_bit),
		.spi_sdi    (spi_sdi),
		.done       (bf_spi_done),
		.rd_data    (rd_data),
		.spi_cs_n   (spi_cs_n),
		.spi_sck    (spi_sck),
		.spi_sdo    (spi_sdo)
	);

	// ====================
	// transmit and acquire path
	// ====================
	delayed_pulser tx_start_pulser (
		.clk    (clk),
		.rst_n  (rst_n),
		.sig_in (bf_tx_en),
		.pulse  (tx_start_pulse)
	);

	echo_acq_fsm echo_acq_fsm_inst (
		.clk                  (clk),
		.rst_n                (rst_n),
		.start                (tx_start_pulse),
		.adc_start_length     (adc_start_length),
		.adc_init_delay       (adc_init_delay),
		.adc_samples_per_echo (adc_samples_per_echo),
		.tx_en                (bf_tx_en_pin),
		.fifo_en              (fifo_en),
		.done                 (fsm_done)
	);

endmodule

`default_nettype wire

/* us_golden.txt */
// kind data_in num_of_bit slave_response start_length init_delay samples_per_echo expected_rd_data
// kind 1 SPI frame only, 2 acquisition only, 3 acquisition started during a frame, all hex
// SPI frames of 1, 8, 12, 17 and 70 bits
1 1                  01 1                  0  0  0  1
1 A5                 08 3C                 0  0  0  3C
1 FFFF               0C 1F0F               0  0  0  F0F
1 1ABCD              11 0F0F1              0  0  0  F0F1
1 3A5C96E1F00D2B4C87 46 1E2D3C4B5A69788796 0  0  0  1E2D3C4B5A69788796
1 3FFFFFFFFFFFFFFFFF 46 0                  0  0  0  0
// acquisition windows
2 0                  00 0                  1  1  1  0
2 0                  00 0                  5  3  8  0
2 0                  00 0                  C  7  20 0
2 0                  00 0                  1  A  3  0
// acquisition while a frame runs
3 249249249249249249 46 36DB6DB6DB6DB6DB6D 4  6  10 36DB6DB6DB6DB6DB6D
3 13579BDF           20 2468ACE0           2  9  5  2468ACE0

/* us_pkg.sv */
// ====================
// shared widths, SCK divider and start delay of the
// ultrasound transmit and receive control path
// ====================

`default_nettype none

package us_pkg;

	// ====================
	// beamformer SPI frame
	// ====================
	localparam int BF_DATA_WIDTH      = 70;  // LM96570 longest frame
	localparam int BF_BIT_COUNT_WIDTH = 8;   // holds 1..70

	// clk cycles per half SCK period
	localparam int SCK_HALF_CYCLES    = 2;
	localparam int SCK_HALF_CNT_WIDTH =     // at least one bit
		(SCK_HALF_CYCLES > 1) ? $clog2(SCK_HALF_CYCLES) : 1;

	// ====================
	// echo acquisition
	// ====================
	localparam int ACQ_CNT_WIDTH      = 32;  // tx length, init delay, samples

	// ====================
	// start pulsers
	// ====================
	localparam int START_DELAY_CYCLES = 10;  // sampled edge to pulse
	localparam int START_DELAY_WIDTH  = 8;   // pulser down-counter

endpackage

`default_nettype wire
